// ==== logic/bus_pkg.sv ====
package bus_pkg;

    localparam int rom_banks_lp = 6;  // 64 KiB banks fitted on the board
    localparam int disp_hold_lp = 2;  // blank cycles before a display access ends
    localparam logic [15:0] open_bus_lp = 16'hffff;

    // one access from the bus master, held while req is high
    typedef struct packed {
        logic [23:1] addr;   // word address
        logic        rnw;
        logic        uds;    // upper byte strobe, active high
        logic        lds;    // lower byte strobe, active high
        logic [15:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [15:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic       rom;
        logic       ram_sys;
        logic       fmode;   // first tilemap chip
        logic       fsft;
        logic       fmap;
        logic       bmode;   // second tilemap chip
        logic       bsft;
        logic       bmap;
        logic       cmode;   // third chip, on the second board
        logic       csft;
        logic       cmap;
        logic [1:0] pal;
        logic       obj;
        logic [2:0] io_rd;   // cabinet read words
        logic       mcu_rd;
        logic       io_wr;
        logic       disp;    // whole display region
    } chip_sel_t;

endpackage

// ==== logic/io_pkg.sv ====
package io_pkg;

    localparam logic [2:0] io_rd_mcu_lp = 3'd4;  // mcu port read offset

    typedef struct packed {
        logic [8:0] joy2;
        logic [8:0] joy1;
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
    } cab_in_t;

    typedef struct packed {
        logic [7:0] joy2;  // sorted directions and buttons
        logic [7:0] joy1;
    } cab_joy_t;

    typedef struct packed {
        logic [7:0] pad;
        logic       vblank;
        logic       service;
        logic [1:0] coin;
        logic [1:0] start;
        logic       joy2_b8;
        logic       joy1_b8;
    } cab_sys_t;

    // same read word, meaning depends on the register offset
    typedef union packed {
        cab_joy_t joy;
        cab_sys_t sys;
    } cab_word_u;

    typedef enum logic [2:0] {
        io_prisel   = 3'd0,
        io_obj_copy = 3'd1,
        io_snd      = 3'd2,
        io_mcu      = 3'd3,
        io_vint_clr = 3'd4,
        io_mixpsel  = 3'd5
    } io_reg_e;

    typedef logic [2:0] ipl_t;  // active low

endpackage

// ==== logic/addr_decoder.sv ====
`timescale 1ns/1ps

module addr_decoder (
    input  logic               req,
    input  bus_pkg::bus_req_t  bus_req,
    output bus_pkg::chip_sel_t cs
);

    logic [23:1] a;
    logic        ram_class;

    assign a = bus_req.addr;

    always_comb begin
        cs = '0;
        if (req) begin
            case (a[21:20])
                2'd0: cs.rom = bus_req.rnw && (a[19:16] < bus_pkg::rom_banks_lp);
                2'd1: ;  // eeprom hole, not fitted
                2'd2: begin
                    cs.disp = 1'b1;
                    if (a[19:18] == 2'b01) begin
                        case (a[15:13])
                            3'd0: cs.fmode = 1'b1;  // mode registers
                            3'd1: cs.fsft  = 1'b1;  // row/col scroll
                            3'd2: cs.fmap  = 1'b1;
                            3'd3: cs.bmode = 1'b1;
                            3'd4: cs.bsft  = 1'b1;
                            3'd5: cs.bmap  = 1'b1;
                            3'd6: begin
                                // third chip packs its groups tighter
                                case (a[11:10])
                                    2'd0:    cs.cmode = 1'b1;
                                    2'd1:    cs.csft  = 1'b1;
                                    2'd2:    cs.cmap  = 1'b1;
                                    default: ;
                                endcase
                            end
                            default: ;
                        endcase
                    end
                end
                2'd3: begin
                    case (a[16:14])
                        3'd3: begin
                            // reads sit below bit 4, writes above
                            if (bus_req.rnw && !a[4]) begin
                                if (a[3:1] < 3'd3)
                                    cs.io_rd[a[2:1]] = 1'b1;
                                else if (a[3:1] == io_pkg::io_rd_mcu_lp)
                                    cs.mcu_rd = 1'b1;
                            end
                            if (!bus_req.rnw && a[4])
                                cs.io_wr = 1'b1;
                        end
                        3'd4:    cs.pal[0]  = 1'b1;
                        3'd5:    cs.pal[1]  = 1'b1;
                        3'd6:    cs.ram_sys = 1'b1;
                        3'd7:    cs.obj     = 1'b1;  // sprite ram
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    assign ram_class = cs.ram_sys | cs.fsft | cs.fmap | cs.bsft | cs.bmap |
                       cs.csft | cs.cmap;

    // the controller read mux relies on a single data source
    always_comb begin
        assert final ($onehot0({cs.rom, ram_class, |cs.pal}))
            else $error("more than one memory select active");
    end

endmodule

// ==== logic/irq_encoder.sv ====
`timescale 1ns/1ps

module irq_encoder (
    input  logic         clk,
    input  logic         rst,
    input  logic         lvbl,
    input  logic         mcu_irq,
    input  logic         nexirq,
    input  logic         vint_clr,
    input  logic         mcu_rd,
    output io_pkg::ipl_t ipl
);

    logic lvbl_l, mcu_irq_l;
    logic vint, secirq;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l    <= 1'b0;
            mcu_irq_l <= 1'b0;
            vint      <= 1'b0;
            secirq    <= 1'b0;
        end else begin
            lvbl_l    <= lvbl;
            mcu_irq_l <= mcu_irq;
            if (vint_clr)
                vint <= 1'b0;
            else if (!lvbl && lvbl_l)
                vint <= 1'b1;  // start of vertical blank
            if (mcu_rd)
                secirq <= 1'b0;  // reading the port acks the mcu
            else if (mcu_irq && !mcu_irq_l)
                secirq <= 1'b1;
        end
    end

    always_comb begin
        if (vint)
            ipl = io_pkg::ipl_t'(~3'd6);
        else if (secirq)
            ipl = io_pkg::ipl_t'(~3'd5);
        else if (!nexirq)
            ipl = io_pkg::ipl_t'(~3'd4);
        else
            ipl = io_pkg::ipl_t'(~3'd0);
    end

    // a clear held past one cycle would swallow the next set edge
    assert property (@(posedge clk) disable iff (rst)
                     (vint_clr || mcu_rd) |=> !(vint_clr || mcu_rd))
        else $error("interrupt clear held longer than one cycle");

endmodule

// ==== logic/cab_inputs.sv ====
`timescale 1ns/1ps

module cab_inputs (
    input  logic              clk,
    input  io_pkg::cab_in_t   cab,
    input  logic [7:0]        dips_a,
    input  logic [7:0]        dips_b,
    input  logic              lvbl,
    input  logic [2:0]        io_rd,
    output io_pkg::cab_word_u cab_word
);

    logic [8:0]        sort1, sort2;
    io_pkg::cab_word_u nxt;

    // directions come out of the harness in reverse order
    function automatic logic [8:0] sort_joy(input logic [8:0] joy);
        return {joy[8:4], joy[0], joy[1], joy[2], joy[3]};
    endfunction

    assign sort1 = sort_joy(cab.joy1);
    assign sort2 = sort_joy(cab.joy2);

    always_comb begin
        nxt = '1;  // nothing selected reads high
        if (io_rd[0]) begin
            nxt.joy.joy2 = sort2[7:0];
            nxt.joy.joy1 = sort1[7:0];
        end else if (io_rd[1]) begin
            nxt.sys.pad     = '1;
            nxt.sys.vblank  = ~lvbl;
            nxt.sys.service = cab.service;
            nxt.sys.coin    = cab.coin;
            nxt.sys.start   = cab.start;
            nxt.sys.joy2_b8 = sort2[8];
            nxt.sys.joy1_b8 = sort1[8];
        end else if (io_rd[2]) begin
            nxt = {dips_b, dips_a};
        end
    end

    always_ff @(posedge clk)
        cab_word <= nxt;

endmodule

// ==== logic/disp_wait.sv ====
`timescale 1ns/1ps

module disp_wait (
    input  logic clk,
    input  logic rst,
    input  logic disp_sel,
    input  logic lvbl,
    input  logic lhbl,
    output logic disp_ready
);

    logic [$clog2(bus_pkg::disp_hold_lp + 1)-1:0] blank_cnt;
    logic blank;
    logic held;

    assign blank = !lvbl || !lhbl;  // either blank opens the window
    assign held  = blank_cnt == bus_pkg::disp_hold_lp;

    // saturates, then stays ready until the access goes away
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blank_cnt <= '0;
        end else if (!disp_sel) begin
            blank_cnt <= '0;
        end else if (!held) begin
            if (blank)
                blank_cnt <= blank_cnt + 1'b1;
            else
                blank_cnt <= '0;  // blank must be consecutive
        end
    end

    assign disp_ready = disp_sel && held;

endmodule

// ==== logic/bus_cycle_ctrl.sv ====
`timescale 1ns/1ps

module bus_cycle_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  bus_pkg::bus_req_t  bus_req,
    input  bus_pkg::chip_sel_t cs,
    input  logic               rom_ok,
    input  logic               ram_ok,
    input  logic               disp_ready,
    input  logic [15:0]        rom_data,
    input  logic [15:0]        ram_data,
    input  logic [15:0]        pal_dout,
    input  logic [15:0]        obj_dout,
    input  logic [15:0]        mcu_dout,
    input  io_pkg::cab_word_u  cab_word,
    output logic               ack,
    output bus_pkg::bus_rsp_t  bus_rsp,
    output logic [7:0]         snd_latch,
    output logic               snreq,
    output logic [15:0]        mcu_din,
    output logic [2:0]         prisel,
    output logic               mixpsel,
    output logic               obj_copy,
    output logic               vint_clr,
    output logic               mcu_rd
);

    typedef enum logic [1:0] {st_idle, st_wait, st_done} state_e;

    state_e             state;
    bus_pkg::chip_sel_t cs_q;
    io_pkg::io_reg_e    wr_reg;
    logic               ok_dly, ram_class, ready, done;

    assign ram_class = cs_q.ram_sys | cs_q.fsft | cs_q.fmap | cs_q.bsft |
                       cs_q.bmap | cs_q.csft | cs_q.cmap;
    // sdram ok settles one cycle late on rom
    assign ready = !(cs_q.rom && !(rom_ok && ok_dly)) &&
                   !(ram_class && !ram_ok) && !(cs_q.disp && !disp_ready);
    assign done   = state == st_wait && ready;
    assign wr_reg = io_pkg::io_reg_e'(bus_req.addr[3:1]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            cs_q      <= '0;
            ok_dly    <= 1'b0;
            ack       <= 1'b0;
            snd_latch <= '0;
            snreq     <= 1'b0;
            mcu_din   <= '0;
            prisel    <= '0;
            mixpsel   <= 1'b0;
            obj_copy  <= 1'b0;
            vint_clr  <= 1'b0;
            mcu_rd    <= 1'b0;
        end else begin
            ok_dly   <= rom_ok;
            snreq    <= 1'b0;
            obj_copy <= 1'b0;
            vint_clr <= 1'b0;
            mcu_rd   <= done && cs_q.mcu_rd;
            case (state)
                st_idle: if (req) begin
                    cs_q  <= cs;
                    state <= st_wait;
                end
                st_wait: if (ready) begin
                    ack   <= 1'b1;
                    state <= st_done;
                    if (cs_q.io_wr) begin
                        case (wr_reg)
                            io_pkg::io_prisel:   if (bus_req.lds) prisel <= bus_req.wdata[2:0];
                            io_pkg::io_obj_copy: obj_copy <= 1'b1;  // starts sprite dma
                            io_pkg::io_snd: begin
                                if (bus_req.lds) snd_latch <= bus_req.wdata[7:0];
                                snreq <= 1'b1;
                            end
                            io_pkg::io_mcu: begin
                                if (bus_req.uds) mcu_din[15:8] <= bus_req.wdata[15:8];
                                if (bus_req.lds) mcu_din[7:0]  <= bus_req.wdata[7:0];
                            end
                            io_pkg::io_vint_clr: vint_clr <= 1'b1;
                            io_pkg::io_mixpsel:  if (bus_req.lds) mixpsel <= bus_req.wdata[0];
                            default: ;  // coin block and expansion
                        endcase
                    end
                end
                st_done: if (!req) begin
                    ack   <= 1'b0;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // read data, captured on the ready cycle
    always_ff @(posedge clk) begin
        if (done)
            bus_rsp.rdata <= ram_class     ? ram_data :
                             cs_q.rom      ? rom_data :
                             |cs_q.pal     ? pal_dout :
                             cs_q.obj      ? obj_dout :
                             |cs_q.io_rd   ? cab_word :
                             cs_q.mcu_rd   ? mcu_dout : bus_pkg::open_bus_lp;
    end

    assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
        else $error("ack raised with no request pending");

endmodule

// ==== logic/main_bus.sv ====
`timescale 1ns/1ps

module main_bus (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  bus_pkg::bus_req_t  bus_req,
    output logic               ack,
    output bus_pkg::bus_rsp_t  bus_rsp,
    output bus_pkg::chip_sel_t cs,
    input  logic [15:0]        rom_data,
    input  logic               rom_ok,
    input  logic [15:0]        ram_data,
    input  logic               ram_ok,
    input  logic [15:0]        pal_dout,
    input  logic [15:0]        obj_dout,
    input  logic [15:0]        mcu_dout,
    input  logic               lvbl,
    input  logic               lhbl,
    input  logic               nexirq,
    input  logic               mcu_irq,
    input  io_pkg::cab_in_t    cab,
    input  logic [7:0]         dips_a,
    input  logic [7:0]         dips_b,
    output logic [7:0]         snd_latch,
    output logic               snreq,
    output logic [15:0]        mcu_din,
    output logic [2:0]         prisel,
    output logic               mixpsel,
    output logic               obj_copy,
    output io_pkg::ipl_t       ipl
);

    logic              disp_ready, vint_clr, mcu_rd;
    io_pkg::cab_word_u cab_word;

    addr_decoder u_dec (.req(req), .bus_req(bus_req), .cs(cs));

    bus_cycle_ctrl u_ctrl (
        .clk(clk), .rst(rst), .req(req), .bus_req(bus_req), .cs(cs),
        .rom_ok(rom_ok), .ram_ok(ram_ok), .disp_ready(disp_ready),
        .rom_data(rom_data), .ram_data(ram_data), .pal_dout(pal_dout),
        .obj_dout(obj_dout), .mcu_dout(mcu_dout), .cab_word(cab_word),
        .ack(ack), .bus_rsp(bus_rsp), .snd_latch(snd_latch), .snreq(snreq),
        .mcu_din(mcu_din), .prisel(prisel), .mixpsel(mixpsel),
        .obj_copy(obj_copy), .vint_clr(vint_clr), .mcu_rd(mcu_rd)
    );

    disp_wait u_disp (
        .clk(clk), .rst(rst), .disp_sel(cs.disp),
        .lvbl(lvbl), .lhbl(lhbl), .disp_ready(disp_ready)
    );

    irq_encoder u_irq (
        .clk(clk), .rst(rst), .lvbl(lvbl), .mcu_irq(mcu_irq), .nexirq(nexirq),
        .vint_clr(vint_clr), .mcu_rd(mcu_rd), .ipl(ipl)
    );

    cab_inputs u_cab (
        .clk(clk), .cab(cab), .dips_a(dips_a), .dips_b(dips_b),
        .lvbl(lvbl), .io_rd(cs.io_rd), .cab_word(cab_word)
    );

endmodule

// ==== tests/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);

    localparam int half_lp       = 50;  // 100 ns period
    localparam int rst_cycles_lp = 10;

    initial begin
        clk = 1'b0;
        forever #(half_lp) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (rst_cycles_lp) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== tests/main_bus_tb.sv ====
`timescale 1ns/1ps

module main_bus_tb;

    typedef enum logic [2:0] {
        chk_none, chk_rdata, chk_snd, chk_mcu, chk_prisel, chk_mixpsel, chk_obj
    } chk_e;

    // which chip select the access should raise
    typedef enum logic [3:0] {
        sel_none, sel_rom, sel_sys, sel_fsft, sel_cmap, sel_fmode, sel_pal0, sel_pal1,
        sel_obj, sel_joy, sel_stat, sel_dip, sel_mcu, sel_wr
    } sel_e;

    typedef struct packed {
        bus_pkg::bus_req_t req;
        logic [15:0]       exp;     // read word or latch value
        chk_e              chk;
        sel_e              sel;
        logic [1:0]        blanks;  // {lvbl, lhbl} during the access
        logic              hold;    // display access stalls in active video
    } entry_t;

    localparam int acc_limit_lp = 200;  // cycles per handshake phase
    localparam int irq_steps_lp = 8;

    logic               clk, rst, req, ack;
    bus_pkg::bus_req_t  bus_req;
    bus_pkg::bus_rsp_t  bus_rsp;
    bus_pkg::chip_sel_t cs;
    logic [15:0]        rom_data, ram_data, pal_dout, obj_dout, mcu_dout, mcu_din;
    logic               rom_ok, ram_ok, lvbl, lhbl, nexirq, mcu_irq;
    io_pkg::cab_in_t    cab;
    logic [7:0]         dips_a, dips_b, snd_latch;
    logic               snreq, mixpsel, obj_copy;
    logic [2:0]         prisel;
    io_pkg::ipl_t       ipl;

    entry_t      table_q[$];
    int          cycles      = 0;
    int          cycle_limit = 0;
    logic [15:0] lfsr        = 16'd7633;
    logic        req_last    = 1'b0;

    clk_gen u_clk (.clk(clk), .rst(rst));

    main_bus DUT (
        .clk(clk), .rst(rst), .req(req), .bus_req(bus_req), .ack(ack), .bus_rsp(bus_rsp),
        .cs(cs), .rom_data(rom_data), .rom_ok(rom_ok), .ram_data(ram_data), .ram_ok(ram_ok),
        .pal_dout(pal_dout), .obj_dout(obj_dout), .mcu_dout(mcu_dout), .lvbl(lvbl),
        .lhbl(lhbl), .nexirq(nexirq), .mcu_irq(mcu_irq), .cab(cab), .dips_a(dips_a),
        .dips_b(dips_b), .snd_latch(snd_latch), .snreq(snreq), .mcu_din(mcu_din),
        .prisel(prisel), .mixpsel(mixpsel), .obj_copy(obj_copy), .ipl(ipl)
    );

    // memory contents, each a mix of the full byte address
    function automatic logic [15:0] rom_word(input logic [23:0] ba);
        return ba[16:1] ^ {ba[23:17], 9'h0a5};
    endfunction

    function automatic logic [15:0] ram_word(input logic [23:0] ba);
        return ba[16:1] + {ba[23:17], 9'h135};
    endfunction

    function automatic logic [15:0] pal_word(input logic [23:0] ba);
        return {ba[8:1], ba[16:9]} ^ {9'h05a, ba[23:17]};
    endfunction

    function automatic logic [15:0] obj_word(input logic [23:0] ba);
        return ~ba[16:1] ^ {ba[23:17], 9'h000};
    endfunction

    // data is junk while ok is low
    assign rom_data = rom_ok ? rom_word({bus_req.addr, 1'b0}) : ~rom_word({bus_req.addr, 1'b0});
    assign ram_data = ram_ok ? ram_word({bus_req.addr, 1'b0}) : ~ram_word({bus_req.addr, 1'b0});
    assign pal_dout = pal_word({bus_req.addr, 1'b0});
    assign obj_dout = obj_word({bus_req.addr, 1'b0});
    assign mcu_dout = 16'h4d21;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    always @(posedge clk) begin
        lfsr = lfsr_step(lfsr);
        rom_ok <= lfsr[0];
        lfsr = lfsr_step(lfsr);
        ram_ok <= lfsr[0];
    end

    // chip selects the memory map gives for each tag
    function automatic bus_pkg::chip_sel_t sel_of(input sel_e t);
        bus_pkg::chip_sel_t s;
        s = '0;
        case (t)
            sel_rom:   s.rom      = 1'b1;
            sel_sys:   s.ram_sys  = 1'b1;
            sel_fsft:  s.fsft     = 1'b1;
            sel_cmap:  s.cmap     = 1'b1;
            sel_fmode: s.fmode    = 1'b1;
            sel_pal0:  s.pal[0]   = 1'b1;
            sel_pal1:  s.pal[1]   = 1'b1;
            sel_obj:   s.obj      = 1'b1;
            sel_joy:   s.io_rd[0] = 1'b1;
            sel_stat:  s.io_rd[1] = 1'b1;
            sel_dip:   s.io_rd[2] = 1'b1;
            sel_mcu:   s.mcu_rd   = 1'b1;
            sel_wr:    s.io_wr    = 1'b1;
            default: ;
        endcase
        s.disp = t inside {sel_fsft, sel_cmap, sel_fmode};  // display region
        return s;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input bus_pkg::bus_rsp_t got,
                              input bus_pkg::bus_rsp_t exp);
        if (got !== exp)
            stop_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            stop_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_ipl(input io_pkg::ipl_t got, input io_pkg::ipl_t exp);
        if (got !== exp)
            stop_run($sformatf("Fail at %0t ns: ipl is %b, expected %b", $time, got, exp));
    endtask

    task automatic check_sel(input bus_pkg::chip_sel_t got, input bus_pkg::chip_sel_t exp);
        if (got !== exp)
            stop_run($sformatf("Fail at %0t ns: cs is %h, expected %h", $time, got, exp));
    endtask

    function automatic bus_pkg::bus_req_t read_req(input logic [23:0] ba);
        bus_pkg::bus_req_t r;
        r.addr  = ba[23:1];
        r.rnw   = 1'b1;
        r.uds   = 1'b1;
        r.lds   = 1'b1;
        r.wdata = '0;
        return r;
    endfunction

    function automatic bus_pkg::bus_req_t write_req(input logic [23:0] ba, input logic [1:0] strb,
                                                    input logic [15:0] data);
        bus_pkg::bus_req_t r;
        r.addr  = ba[23:1];
        r.rnw   = 1'b0;
        r.uds   = strb[1];
        r.lds   = strb[0];
        r.wdata = data;
        return r;
    endfunction

    function automatic entry_t make_entry(input bus_pkg::bus_req_t r, input logic [15:0] exp,
                                          input chk_e chk, input sel_e sel,
                                          input logic [1:0] blanks, input logic hold);
        entry_t e;
        e.req    = r;
        e.exp    = exp;
        e.chk    = chk;
        e.sel    = sel;
        e.blanks = blanks;
        e.hold   = hold;
        return e;
    endfunction

    task automatic add_read(input logic [23:0] ba, input logic [15:0] exp, input sel_e sel,
                            input logic [1:0] blanks, input logic hold);
        table_q.push_back(make_entry(read_req(ba), exp, chk_rdata, sel, blanks, hold));
    endtask

    task automatic add_write(input logic [23:0] ba, input logic [1:0] strb,
                             input logic [15:0] data, input sel_e sel, input chk_e chk,
                             input logic [15:0] exp);
        table_q.push_back(make_entry(write_req(ba, strb, data), exp, chk, sel, 2'b11, 1'b0));
    endtask

    task automatic build_table();
        add_read(24'h012344, rom_word(24'h012344), sel_rom, 2'b11, 1'b0);
        add_read(24'h05fffe, rom_word(24'h05fffe), sel_rom, 2'b11, 1'b0);
        add_read(24'h060000, 16'hffff, sel_none, 2'b11, 1'b0);  // bank 6 not fitted
        add_write(24'h001000, 2'b11, 16'h5555, sel_none, chk_rdata, 16'hffff);
        add_read(24'h100000, 16'hffff, sel_none, 2'b11, 1'b0);  // eeprom hole
        add_read(24'h318abc, ram_word(24'h318abc), sel_sys, 2'b11, 1'b0);
        add_read(24'h318002, ram_word(24'h318002), sel_sys, 2'b11, 1'b0);
        add_read(24'h310046, pal_word(24'h310046), sel_pal0, 2'b11, 1'b0);
        add_read(24'h3140a2, pal_word(24'h3140a2), sel_pal1, 2'b11, 1'b0);
        add_read(24'h31c010, obj_word(24'h31c010), sel_obj, 2'b11, 1'b0);
        add_read(24'h30c000, 16'ha85c, sel_joy, 2'b11, 1'b0);  // joysticks, directions reversed
        add_read(24'h30c002, 16'hff59, sel_stat, 2'b11, 1'b0);
        add_read(24'h30c002, 16'hffd9, sel_stat, 2'b01, 1'b0);  // vblank bit set
        add_read(24'h30c004, 16'h813c, sel_dip, 2'b11, 1'b0);
        add_read(24'h30c008, 16'h4d21, sel_mcu, 2'b11, 1'b0);
        add_write(24'h30c014, 2'b01, 16'h00a7, sel_wr, chk_snd, 16'h00a7);
        add_write(24'h30c016, 2'b11, 16'hbeef, sel_wr, chk_mcu, 16'hbeef);
        add_write(24'h30c016, 2'b01, 16'h1234, sel_wr, chk_mcu, 16'hbe34);  // low lane only
        add_write(24'h30c010, 2'b01, 16'h0005, sel_wr, chk_prisel, 16'h0005);
        add_write(24'h30c01a, 2'b01, 16'h0001, sel_wr, chk_mixpsel, 16'h0001);
        add_write(24'h30c012, 2'b01, 16'h0000, sel_wr, chk_obj, 16'h0000);  // sprite dma
        add_read(24'h242000, ram_word(24'h242000), sel_fsft, 2'b11, 1'b1);  // scroll ram, no blank
        add_read(24'h24c800, ram_word(24'h24c800), sel_cmap, 2'b10, 1'b0);
        add_read(24'h240000, 16'hffff, sel_fmode, 2'b10, 1'b0);  // mode regs, no read path
        add_read(24'h012346, rom_word(24'h012346), sel_rom, 2'b11, 1'b0);
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > acc_limit_lp)
                stop_run($sformatf("ack did not go to %0b within %0d cycles", level, n));
        end while (ack !== level);
    endtask

    task automatic settle(input int n);
        repeat (n) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic run_access(input entry_t e);
        @(posedge clk);
        lvbl    <= e.blanks[1];
        lhbl    <= e.blanks[0];
        bus_req <= e.req;
        req     <= 1'b1;
        @(negedge clk);
        check_sel(cs, sel_of(e.sel));
        if (e.hold) begin
            repeat (20) begin
                @(negedge clk);
                if (ack)
                    stop_run("display access was acknowledged during active video");
            end
            @(posedge clk);
            lhbl <= 1'b0;  // open a horizontal blank
        end
        wait_ack(1'b1);
        // one-cycle strobes line up with the first ack cycle
        check_byte("snreq", {7'd0, snreq}, {7'd0, (e.chk == chk_snd)});
        check_byte("obj_copy", {7'd0, obj_copy}, {7'd0, (e.chk == chk_obj)});
        @(posedge clk);
        req <= 1'b0;
        wait_ack(1'b0);
        @(posedge clk);
        lvbl <= 1'b1;
        lhbl <= 1'b1;
        @(negedge clk);
    endtask

    task automatic check_result(input entry_t e);
        case (e.chk)
            chk_rdata:   check_word("bus_rsp", bus_rsp, e.exp);
            chk_snd:     check_byte("snd_latch", snd_latch, e.exp[7:0]);
            chk_mcu:     check_word("mcu_din", mcu_din, e.exp);
            chk_prisel:  check_byte("prisel", {5'd0, prisel}, e.exp[7:0]);
            chk_mixpsel: check_byte("mixpsel", {7'd0, mixpsel}, e.exp[7:0]);
            default: ;
        endcase
    endtask

    task automatic irq_sequence();
        entry_t clr_vint, rd_mcu;
        clr_vint = make_entry(write_req(24'h30c018, 2'b11, 16'h0), 16'h0, chk_none, sel_wr,
                              2'b11, 1'b0);
        rd_mcu   = make_entry(read_req(24'h30c008), 16'h4d21, chk_rdata, sel_mcu,
                              2'b11, 1'b0);
        run_access(clr_vint);  // vint left over from the blanked status read
        settle(1);
        check_ipl(ipl, 3'b111);
        @(posedge clk);
        lvbl <= 1'b0;
        settle(2);
        check_ipl(ipl, ~3'd6);
        run_access(clr_vint);
        settle(1);
        check_ipl(ipl, 3'b111);
        @(posedge clk);
        mcu_irq <= 1'b1;
        settle(2);
        check_ipl(ipl, ~3'd5);
        @(posedge clk);
        mcu_irq <= 1'b0;
        settle(2);
        check_ipl(ipl, ~3'd5);  // held until the port is read
        @(posedge clk);
        lvbl <= 1'b0;
        settle(2);
        check_ipl(ipl, ~3'd6);
        run_access(clr_vint);
        settle(1);
        check_ipl(ipl, ~3'd5);
        run_access(rd_mcu);
        check_result(rd_mcu);
        settle(1);
        check_ipl(ipl, 3'b111);
        @(posedge clk);
        nexirq <= 1'b0;
        settle(2);
        check_ipl(ipl, ~3'd4);
        @(posedge clk);
        nexirq <= 1'b1;
        settle(2);
        check_ipl(ipl, 3'b111);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit)
            stop_run($sformatf("run timed out after %0d cycles", cycles));
    end

    // ack may only outlast req by one cycle
    always @(negedge clk) begin
        if (!rst && ack && !req && !req_last)
            stop_run("ack is high while req has been low for a full cycle");
        req_last = req;
    end

    initial begin
        req         = 1'b0;
        bus_req     = '0;
        rom_ok      = 1'b0;
        ram_ok      = 1'b0;
        lvbl        = 1'b1;
        lhbl        = 1'b1;
        nexirq      = 1'b1;
        mcu_irq     = 1'b0;
        cab.joy1    = 9'h153;
        cab.joy2    = 9'h0a1;
        cab.start   = 2'b10;
        cab.coin    = 2'b01;
        cab.service = 1'b1;
        dips_a      = 8'h3c;
        dips_b      = 8'h81;
        build_table();
        cycle_limit = (table_q.size() + irq_steps_lp) * acc_limit_lp + 100;
        wait (rst === 1'b0);
        @(negedge clk);
        if (ack !== 1'b0)
            stop_run("ack is high after reset");
        check_ipl(ipl, 3'b111);
        foreach (table_q[i]) begin
            run_access(table_q[i]);
            check_result(table_q[i]);
        end
        irq_sequence();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
logic/bus_pkg.sv
logic/io_pkg.sv
logic/addr_decoder.sv
logic/irq_encoder.sv
logic/cab_inputs.sv
logic/disp_wait.sv
logic/bus_cycle_ctrl.sv
logic/main_bus.sv
tests/clk_gen.sv
tests/main_bus_tb.sv
